// File: compile.f
+incdir+source
source/rpPkg.sv
source/rpRegBus.sv
source/rpDriveCtrl.sv
source/rpMaintReg.sv
source/rpDiagReadDecoder.sv
source/rpDrive.sv
verif/rpDrive_assert.sv
verif/rpDrive_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the RP drive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module rpDrive_tb -f compile.f

./obj_dir/VrpDrive_tb +verilator+error+limit+100 | tee sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
   echo "run.sh: simulation passed"
   exit 0
else
   echo "run.sh: simulation failed"
   exit 1
fi

// File: source/rpDiagReadDecoder.sv
////////////////////////////////////////////////////////////////////////////
// RP diagnostic read decoder
// Serial read data to sync, zero, field envelopes, word clock and sector
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rp_macros.svh"

module rpDiagReadDecoder
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           dmd,
   input  wire                           dclk,
   input  wire                           dind,
   input  wire                           dsck,
   input  wire                           drdd,
   output logic                          sbd,
   output logic                          zd,
   output logic                          dfe,
   output logic                          ece,
   output logic                          dwrd,
   output logic [`RP_SECT_WIDTH-1:0]     sector
);

   logic                           dclkPrev;
   logic                           dindPrev;
   logic                           dsckPrev;
   logic                           dclkRise;
   logic                           dindRise;
   logic                           dsckRise;
   logic [`RP_HIST_WIDTH-1:0]      history;
   logic [`RP_HIST_WIDTH-1:0]      histNext;
   logic [`RP_BITCNT_WIDTH-1:0]    bitCnt;

   ////////////////////////////////////////////////////////////////////////
   // Edge detect on the software clocks
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dclkPrev <= 1'b0;
         dindPrev <= 1'b0;
         dsckPrev <= 1'b0;
      end
      else
      begin
         dclkPrev <= dclk & dmd;
         dindPrev <= dind & dmd;
         dsckPrev <= dsck & dmd;
      end
   end

   assign dclkRise = dclk & ~dclkPrev;
   assign dindRise = dind & ~dindPrev;
   assign dsckRise = dsck & ~dsckPrev;

   ////////////////////////////////////////////////////////////////////////
   // Serial read path
   ////////////////////////////////////////////////////////////////////////

   assign histNext = {history[`RP_HIST_WIDTH-2:0], drdd};

   // History starts as all ones, so zd needs a full 16 zero bits
   assign zd = (history == '0);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         history <= '1;
         bitCnt  <= '0;
         sbd     <= 1'b0;
         dfe     <= 1'b0;
         ece     <= 1'b0;
         dwrd    <= 1'b0;
      end
      else if (!dmd)
      begin
         history <= '1;
         bitCnt  <= '0;
         sbd     <= 1'b0;
         dfe     <= 1'b0;
         ece     <= 1'b0;
         dwrd    <= 1'b0;
      end
      else if (dclkRise)
      begin
         history <= histNext;
         if (!sbd)
         begin
            // Hunting for the sync byte
            if (histNext[7:0] == `RP_SYNC_BYTE)
            begin
               sbd    <= 1'b1;
               dfe    <= 1'b1;
               bitCnt <= '0;
            end
         end
         else if (dfe)
         begin
            // Word clock flips on each 16 bit boundary
            if (&bitCnt[3:0])
               dwrd <= ~dwrd;
            if (bitCnt == `RP_DATA_BITS - 1'b1)
            begin
               dfe    <= 1'b0;
               ece    <= 1'b1;
               bitCnt <= '0;
            end
            else
               bitCnt <= bitCnt + 1'b1;
         end
         else if (ece)
         begin
            // End of ECC field, back to sync hunt
            if (bitCnt == `RP_ECC_BITS - 1'b1)
            begin
               ece    <= 1'b0;
               sbd    <= 1'b0;
               bitCnt <= '0;
            end
            else
               bitCnt <= bitCnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Sector counter
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         sector <= '0;
      else if (!dmd | dindRise)
         sector <= '0;
      else if (dsckRise)
      begin
         // Wraps at sectors per track
         if (sector == `RP_SECTORS - 1'b1)
            sector <= '0;
         else
            sector <= sector + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/rpDrive.sv
////////////////////////////////////////////////////////////////////////////
// RP drive register block top level
// Register bus, drive control, RPMR and diagnostic read decoder
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rp_macros.svh"

module rpDrive
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           clr,
   input  wire                           regReq,
   input  wire                           regWrite,
   input  wire  [`RP_ADDR_WIDTH-1:0]     regAddr,
   input  wire  [`RP_DATA_WIDTH-1:0]     regDataIn,
   output logic                          regAck,
   output logic [`RP_REG_WIDTH-1:0]      regDataOut
);

   import rpPkg::*;

   // Bus side
   rpWriteWord_t                 dataIn;
   logic                         cs1Write;
   logic                         mrWrite;
   // Register contents
   logic [`RP_CS_WIDTH-1:0]      csReg;
   logic [`RP_REG_WIDTH-1:0]     dsReg;
   logic [`RP_REG_WIDTH-1:0]     mrReg;
   logic [`RP_SECT_WIDTH-1:0]    sector;
   // Drive state
   logic                         dry;
   logic                         drvClr;
   logic                         dmd;
   // Diagnostic bits and decoder flags
   logic                         dclk;
   logic                         dind;
   logic                         dsck;
   logic                         drdd;
   logic                         sbd;
   logic                         zd;
   logic                         dfe;
   logic                         ece;
   logic                         dwrd;

   rpRegBus u_rpRegBus
   (
      .clk        (clk),
      .rst        (rst),
      .regReq     (regReq),
      .regWrite   (regWrite),
      .regAddr    (regAddr),
      .regDataIn  (regDataIn),
      .csReg      (csReg),
      .dsReg      (dsReg),
      .mrReg      (mrReg),
      .sector     (sector),
      .regAck     (regAck),
      .regDataOut (regDataOut),
      .cs1Write   (cs1Write),
      .mrWrite    (mrWrite),
      .dataIn     (dataIn)
   );

   rpDriveCtrl u_rpDriveCtrl
   (
      .clk        (clk),
      .rst        (rst),
      .clr        (clr),
      .cs1Write   (cs1Write),
      .dataIn     (dataIn),
      .dmd        (dmd),
      .csReg      (csReg),
      .dsReg      (dsReg),
      .dry        (dry),
      .drvClr     (drvClr)
   );

   rpMaintReg u_rpMaintReg
   (
      .clk        (clk),
      .rst        (rst),
      .clr        (clr),
      .drvClr     (drvClr),
      .dataIn     (dataIn),
      .mrWrite    (mrWrite),
      .dry        (dry),
      .sbd        (sbd),
      .zd         (zd),
      .dfe        (dfe),
      .ece        (ece),
      .dwrd       (dwrd),
      .mrReg      (mrReg),
      .dmd        (dmd),
      .dclk       (dclk),
      .dind       (dind),
      .dsck       (dsck),
      .drdd       (drdd)
   );

   rpDiagReadDecoder u_rpDiagReadDecoder
   (
      .clk        (clk),
      .rst        (rst),
      .dmd        (dmd),
      .dclk       (dclk),
      .dind       (dind),
      .dsck       (dsck),
      .drdd       (drdd),
      .sbd        (sbd),
      .zd         (zd),
      .dfe        (dfe),
      .ece        (ece),
      .dwrd       (dwrd),
      .sector     (sector)
   );

endmodule

`default_nettype wire

// File: source/rpDriveCtrl.sv
////////////////////////////////////////////////////////////////////////////
// RP drive control
// RPCS1 function code, GO decode, drive clear and busy timer
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rp_macros.svh"

module rpDriveCtrl
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           clr,
   input  wire                           cs1Write,
   input  wire  rpPkg::rpWriteWord_t     dataIn,
   input  wire                           dmd,
   output logic [`RP_CS_WIDTH-1:0]       csReg,
   output logic [`RP_REG_WIDTH-1:0]      dsReg,
   output logic                          dry,
   output logic                          drvClr
);

   logic [`RP_FUNC_WIDTH-1:0]   funCode;
   logic [`RP_BUSY_WIDTH-1:0]   busyCnt;
   logic                        goWrite;
   logic                        clrGo;

   // GO with the drive clear code
   assign goWrite = cs1Write & dataIn.cs1.go;
   assign clrGo   = goWrite & (dataIn.cs1.fun == `RP_FUNC_DRVCLR);

   // Function code register, loads only while ready
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         funCode <= '0;
      else if (clr)
         funCode <= '0;
      else if (cs1Write & dry)
         funCode <= dataIn.cs1.fun;
   end

   // One clock drive clear pulse
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         drvClr <= 1'b0;
      else
         drvClr <= clrGo;
   end

   // Busy timer, other functions just hold off ready
   // clr does not abort it
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         busyCnt <= '0;
      else if (goWrite & ~clrGo & dry)
         busyCnt <= `RP_BUSY_CYCLES;
      else if (busyCnt != '0)
         busyCnt <= busyCnt - 1'b1;
   end

   assign dry = (busyCnt == '0);

   // GO reads back set while the function runs
   assign csReg = {funCode, ~dry};

   // RPDS
   always_comb
   begin
      dsReg = '0;
      dsReg[`RP_DS_DRY_BIT] = dry;
      dsReg[`RP_DS_DMD_BIT] = dmd;
   end

endmodule

`default_nettype wire

// File: source/rpMaintReg.sv
////////////////////////////////////////////////////////////////////////////
// RP maintenance register (RPMR)
// Diagnostic mode and the software driven diagnostic bits
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rp_macros.svh"

module rpMaintReg
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           clr,
   input  wire                           drvClr,
   input  wire  rpPkg::rpWriteWord_t     dataIn,
   input  wire                           mrWrite,
   input  wire                           dry,
   input  wire                           sbd,
   input  wire                           zd,
   input  wire                           dfe,
   input  wire                           ece,
   input  wire                           dwrd,
   output logic [`RP_REG_WIDTH-1:0]      mrReg,
   output logic                          dmd,
   output logic                          dclk,
   output logic                          dind,
   output logic                          dsck,
   output logic                          drdd
);

   // drdd, dsck, dind, dclk, same order as in the register
   logic [3:0]   diagBits;

   // Mode only changes while the drive is ready
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dmd <= 1'b0;
      else if (clr | drvClr)
         dmd <= 1'b0;
      else if (mrWrite & dry)
         dmd <= dataIn.mr.dmd;
   end

   // Diagnostic bits, forced low outside diagnostic mode
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         diagBits <= '0;
      else if (clr | drvClr | ~dmd)
         diagBits <= '0;
      else if (mrWrite)
         diagBits <= {dataIn.mr.drdd, dataIn.mr.dsck, dataIn.mr.dind, dataIn.mr.dclk};
   end

   assign drdd = diagBits[3];
   assign dsck = diagBits[2];
   assign dind = diagBits[1];
   assign dclk = diagBits[0];

   // Upper six bits read as zero
   assign mrReg = {6'b0, sbd, zd, dfe, ece, dwrd, diagBits, dmd};

endmodule

`default_nettype wire

// File: source/rpPkg.sv
////////////////////////////////////////////////////////////////////////////
// RP drive shared types
// Host write word with control and maintenance views
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "rp_macros.svh"

package rpPkg;

   //
   // Host write word, decoded as RPCS1 or RPMR
   // Same 36 bits, field meaning depends on the addressed register
   //
   typedef union packed
   {
      // RPCS1 view
      struct packed
      {
         logic [`RP_DATA_WIDTH-7:0]   unused;
         // Function code
         logic [`RP_FUNC_WIDTH-1:0]   fun;
         // Go bit
         logic                        go;
      } cs1;

      // RPMR view
      struct packed
      {
         logic [`RP_DATA_WIDTH-6:0]   unused;
         // Diagnostic read data
         logic                        drdd;
         // Diagnostic sector clock
         logic                        dsck;
         // Diagnostic index pulse
         logic                        dind;
         // Diagnostic clock
         logic                        dclk;
         // Diagnostic mode
         logic                        dmd;
      } mr;
   } rpWriteWord_t;

endpackage

`default_nettype wire

// File: source/rpRegBus.sv
////////////////////////////////////////////////////////////////////////////
// RP register bus slave
// Four-phase req/ack handshake, write strobes and read data mux
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rp_macros.svh"

module rpRegBus
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           regReq,
   input  wire                           regWrite,
   input  wire  [`RP_ADDR_WIDTH-1:0]     regAddr,
   input  wire  [`RP_DATA_WIDTH-1:0]     regDataIn,
   input  wire  [`RP_CS_WIDTH-1:0]       csReg,
   input  wire  [`RP_REG_WIDTH-1:0]      dsReg,
   input  wire  [`RP_REG_WIDTH-1:0]      mrReg,
   input  wire  [`RP_SECT_WIDTH-1:0]     sector,
   output logic                          regAck,
   output logic [`RP_REG_WIDTH-1:0]      regDataOut,
   output logic                          cs1Write,
   output logic                          mrWrite,
   output rpPkg::rpWriteWord_t           dataIn
);

   logic [1:0]                 state;
   logic                       wrReq;
   logic [`RP_REG_WIDTH-1:0]   rdWord;

   // Write data goes straight to the registers with the strobe
   assign dataIn = regDataIn;

   // Strobe only from idle, so a held request writes once
   assign wrReq    = (state == `RP_BUS_IDLE) & regReq & regWrite;
   assign cs1Write = wrReq & (regAddr == `RP_ADDR_CS1);
   assign mrWrite  = wrReq & (regAddr == `RP_ADDR_MR);

   // RPDS and RPLA are read only
   assign regAck = (state == `RP_BUS_ACK);

   ////////////////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      rdWord = '0;
      case (regAddr)
         `RP_ADDR_CS1:
         begin
            rdWord[`RP_CS_WIDTH-1:0] = csReg;
         end
         `RP_ADDR_DS:
         begin
            rdWord = dsReg;
         end
         `RP_ADDR_MR:
         begin
            rdWord = mrReg;
         end
         `RP_ADDR_LA:
         begin
            // Sector count sits above the unused low bits
            rdWord[`RP_LA_SECT_LSB +: `RP_SECT_WIDTH] = sector;
         end
         default:
         begin
            // Unknown address reads as zero
            rdWord = '0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////
   // Handshake FSM
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= `RP_BUS_IDLE;
      end
      else
      begin
         case (state)
            `RP_BUS_IDLE:
            begin
               if (regReq)
                  state <= `RP_BUS_STROBE;
            end
            `RP_BUS_STROBE:
            begin
               state <= `RP_BUS_ACK;
            end
            `RP_BUS_ACK:
            begin
               // Hold ack until the host lets go
               if (!regReq)
                  state <= `RP_BUS_IDLE;
            end
            default:
            begin
               state <= `RP_BUS_IDLE;
            end
         endcase
      end
   end

   // Read word captured as ack rises, after any write has landed
   always_ff @(posedge clk)
   begin
      if (state == `RP_BUS_STROBE)
         regDataOut <= rdWord;
   end

endmodule

`default_nettype wire

// File: source/rp_macros.svh
////////////////////////////////////////////////////////////////////////////
// RP drive register block constants
// Addresses, bit positions, decoder field lengths and timer values
////////////////////////////////////////////////////////////////////////////
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// Bus widths
`define RP_ADDR_WIDTH   5
`define RP_DATA_WIDTH   36
`define RP_REG_WIDTH    16
`define RP_CS_WIDTH     6

// Drive register addresses
`define RP_ADDR_CS1     5'd0
`define RP_ADDR_DS      5'd1
`define RP_ADDR_MR      5'd3
`define RP_ADDR_LA      5'd7

// Register bus FSM states
`define RP_BUS_IDLE     2'd0
`define RP_BUS_STROBE   2'd1
`define RP_BUS_ACK      2'd2

// Function codes
`define RP_FUNC_WIDTH   5
`define RP_FUNC_DRVCLR  5'o04

// RPDS bit positions
`define RP_DS_DRY_BIT   7
`define RP_DS_DMD_BIT   1

// Sector count position in RPLA
`define RP_LA_SECT_LSB  6
`define RP_SECT_WIDTH   5
`define RP_SECTORS      5'd20

// Diagnostic read decoder
`define RP_HIST_WIDTH   16
`define RP_SYNC_BYTE    8'h01
`define RP_BITCNT_WIDTH 6
`define RP_DATA_BITS    6'd32
`define RP_ECC_BITS     6'd16

// Busy period after a non-clear GO
`define RP_BUSY_WIDTH   4
`define RP_BUSY_CYCLES  4'd8

`endif

// File: verif/rpDrive_assert.sv
////////////////////////////////////////////////////////////////////////////
// RP drive bound assertions
// Register bus handshake timing and drive clear effect on diagnostic mode
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module rpDrive_assert
(
   input wire clk,
   input wire rst,
   input wire regReq,
   input wire regAck,
   input wire drvClr,
   input wire dmd
);

   // Failures seen so far, read by the testbench at the end
   int failCount = 0;

   ////////////////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////////////////

   // Ack rises two edges after the first edge that sees the request
   ackLatencyCheck: assert property (@(posedge clk) disable iff (rst)
      $rose(regAck) == ($past(regReq, 2) && !$past(regReq, 3)))
   else
   begin
      failCount++;
      $error("regAck did not rise two cycles after regReq was first seen high");
   end

   // Ack is held until the host lets go
   ackReleaseCheck: assert property (@(posedge clk) disable iff (rst)
      $fell(regAck) |-> !$past(regReq))
   else
   begin
      failCount++;
      $error("regAck fell while regReq was still high");
   end

   ////////////////////////////////////////////////////////////////////////
   // Drive clear
   ////////////////////////////////////////////////////////////////////////

   // Mode must be gone one cycle after the clear pulse
   drvClrModeCheck: assert property (@(posedge clk) disable iff (rst)
      drvClr |=> !dmd)
   else
   begin
      failCount++;
      $error("dmd still high in the cycle after drvClr");
   end

endmodule

bind rpDrive rpDrive_assert u_rpDriveAssert
(
   .clk    (clk),
   .rst    (rst),
   .regReq (regReq),
   .regAck (regAck),
   .drvClr (drvClr),
   .dmd    (dmd)
);

`default_nettype wire

// File: verif/rpDrive_tb.sv
////////////////////////////////////////////////////////////////////////////
// RP drive register block testbench
// Bus accesses over req/ack, register model checks, final verdict
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "rp_macros.svh"

module rpDrive_tb;

   localparam int ACK_TIMEOUT       = 50;
   localparam int READY_TIMEOUT     = 100;
   localparam int SECTORS_PER_TRACK = 20;
   localparam logic [4:0] SEEK_CODE = 5'o02;

   logic                          clk;
   logic                          rst;
   logic                          clr;
   logic                          regReq;
   logic                          regWrite;
   logic [`RP_ADDR_WIDTH-1:0]     regAddr;
   logic [`RP_DATA_WIDTH-1:0]     regDataIn;
   logic                          regAck;
   logic [`RP_REG_WIDTH-1:0]      regDataOut;

   int   errors;
   int   checks;
   // Last serial bit sent, shows up as drdd in RPMR
   logic lastDrdd;

   rpDrive u_rpDrive
   (
      .clk        (clk),
      .rst        (rst),
      .clr        (clr),
      .regReq     (regReq),
      .regWrite   (regWrite),
      .regAddr    (regAddr),
      .regDataIn  (regDataIn),
      .regAck     (regAck),
      .regDataOut (regDataOut)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////
   // Expected register words
   ////////////////////////////////////////////////////////////////////////

   // RPMR write word, mode in bit 0 then dclk, dind, dsck, drdd
   function automatic logic [`RP_DATA_WIDTH-1:0] mrWord(input logic dmd, input logic dclk,
                                                         input logic dind, input logic dsck,
                                                         input logic drdd);
      mrWord = '0;
      mrWord[4:0] = {drdd, dsck, dind, dclk, dmd};
   endfunction

   // RPCS1 write word, function in 5:1 and GO in 0
   function automatic logic [`RP_DATA_WIDTH-1:0] cs1Word(input logic [4:0] fun, input logic go);
      cs1Word = '0;
      cs1Word[5:0] = {fun, go};
   endfunction

   function automatic logic [15:0] cs1Expect(input logic [4:0] fun, input logic go);
      cs1Expect = '0;
      cs1Expect[5:0] = {fun, go};
   endfunction

   // RPMR readback, sbd in bit 9 down to dmd in bit 0
   function automatic logic [15:0] mrExpect(input logic sbd, input logic zd, input logic dfe,
                                            input logic ece, input logic dwrd,
                                            input logic drdd, input logic dsck,
                                            input logic dind, input logic dclk,
                                            input logic dmd);
      mrExpect = '0;
      mrExpect[9:0] = {sbd, zd, dfe, ece, dwrd, drdd, dsck, dind, dclk, dmd};
   endfunction

   function automatic logic [15:0] dsExpect(input logic dry, input logic dmd);
      dsExpect = '0;
      dsExpect[`RP_DS_DRY_BIT] = dry;
      dsExpect[`RP_DS_DMD_BIT] = dmd;
   endfunction

   // Sector count sits in the RPLA sector field
   function automatic logic [15:0] laExpect(input int n);
      laExpect = '0;
      laExpect[`RP_LA_SECT_LSB +: `RP_SECT_WIDTH] = n[`RP_SECT_WIDTH-1:0];
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////////////////////////////////////

   task automatic waitAck(input logic level, input string what);
      int cycles;
      cycles = 0;
      while (regAck !== level && cycles < ACK_TIMEOUT)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (regAck !== level)
      begin
         errors++;
         $display("ERROR: regAck never went to %0d during %s", level, what);
      end
   endtask

   // One full four-phase cycle, read word taken while ack is high
   task automatic busAccess(input logic write, input logic [`RP_ADDR_WIDTH-1:0] addr,
                            input logic [`RP_DATA_WIDTH-1:0] data,
                            output logic [15:0] rdata, input string what);
      @(posedge clk);
      #1;
      regReq    = 1'b1;
      regWrite  = write;
      regAddr   = addr;
      regDataIn = data;
      waitAck(1'b1, what);
      rdata  = regDataOut;
      regReq = 1'b0;
      waitAck(1'b0, what);
   endtask

   task automatic busWrite(input logic [`RP_ADDR_WIDTH-1:0] addr,
                           input logic [`RP_DATA_WIDTH-1:0] data, input string what);
      logic [15:0] unused;
      busAccess(1'b1, addr, data, unused, what);
   endtask

   task automatic busRead(input logic [`RP_ADDR_WIDTH-1:0] addr, output logic [15:0] data,
                          input string what);
      busAccess(1'b0, addr, '0, data, what);
   endtask

   task automatic checkValue(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
      checks++;
      assert (actual === expected)
      else
      begin
         errors++;
         $display("MISMATCH %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic readCheck(input logic [`RP_ADDR_WIDTH-1:0] addr, input logic [15:0] expected,
                            input string name);
      logic [15:0] rd;
      busRead(addr, rd, name);
      checkValue(name, expected, rd);
   endtask

   // Poll RPDS until the busy period is over
   task automatic waitReady();
      logic [15:0] ds;
      int          polls;
      ds    = '0;
      polls = 0;
      while (!ds[`RP_DS_DRY_BIT] && polls < READY_TIMEOUT)
      begin
         busRead(`RP_ADDR_DS, ds, "ready poll");
         polls++;
      end
      if (!ds[`RP_DS_DRY_BIT])
      begin
         errors++;
         $display("ERROR: drive never returned to ready after GO");
      end
   endtask

   // One serial bit, dclk low then high with the data held
   task automatic shiftBit(input logic b);
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, b), "serial bit low");
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b1, 1'b0, 1'b0, b), "serial bit high");
      lastDrdd = b;
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////

   initial
   begin : stimulus
      logic [15:0]  rd;
      logic [31:0]  rnd;
      logic [3:0]   bits;
      logic [7:0]   syncByte;
      int           n;
      int           i;
      int           assertFails;

      clk       = 1'b0;
      rst       = 1'b1;
      clr       = 1'b0;
      regReq    = 1'b0;
      regWrite  = 1'b0;
      regAddr   = '0;
      regDataIn = '0;
      errors    = 0;
      checks    = 0;
      lastDrdd  = 1'b0;
      syncByte  = `RP_SYNC_BYTE;
      void'($urandom(32'h451f914a));

      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      // Reset state
      readCheck(`RP_ADDR_DS, dsExpect(1'b1, 1'b0), "ds after reset");
      readCheck(`RP_ADDR_MR, 16'h0000, "mr after reset");
      readCheck(`RP_ADDR_LA, laExpect(0), "la after reset");

      // Mode loads while ready
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "mode on");
      readCheck(`RP_ADDR_MR, mrExpect(0, 0, 0, 0, 0, 0, 0, 0, 0, 1), "mode on readback");
      readCheck(`RP_ADDR_DS, dsExpect(1'b1, 1'b1), "ds shows dmd");
      busWrite(`RP_ADDR_MR, mrWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), "mode off");

      // Mode write during the seek busy period is dropped
      busWrite(`RP_ADDR_CS1, cs1Word(SEEK_CODE, 1'b1), "seek go");
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "mode while busy");
      readCheck(`RP_ADDR_MR, 16'h0000, "mode ignored while busy");
      waitReady();
      readCheck(`RP_ADDR_CS1, cs1Expect(SEEK_CODE, 1'b0), "cs1 after seek");

      // Diagnostic bits held low with mode off
      for (i = 0; i < 4; i++)
      begin
         rnd  = $urandom();
         bits = rnd[3:0];
         busWrite(`RP_ADDR_MR, mrWord(1'b0, bits[0], bits[1], bits[2], bits[3]), "bits off");
         readCheck(`RP_ADDR_MR, 16'h0000, "diag bits mode off");
      end

      // And written through with mode on
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "mode on");
      for (i = 0; i < 4; i++)
      begin
         rnd  = $urandom();
         bits = rnd[3:0];
         busWrite(`RP_ADDR_MR, mrWord(1'b1, bits[0], bits[1], bits[2], bits[3]), "bits on");
         busRead(`RP_ADDR_MR, rd, "diag bits mode on");
         checkValue("diag bits mode on",
                    mrExpect(0, 0, 0, 0, 0, bits[3], bits[2], bits[1], bits[0], 1),
                    rd & 16'h001F);
      end

      // Drive clear GO wipes mode and bits
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b1, 1'b1, 1'b1, 1'b1), "all bits");
      busRead(`RP_ADDR_MR, rd, "all bits readback");
      checkValue("all bits readback", 16'h001F, rd & 16'h001F);
      busWrite(`RP_ADDR_CS1, cs1Word(`RP_FUNC_DRVCLR, 1'b1), "drive clear go");
      readCheck(`RP_ADDR_MR, 16'h0000, "mr after drive clear");
      readCheck(`RP_ADDR_DS, dsExpect(1'b1, 1'b0), "ds after drive clear");

      // Controller clear does the same
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "mode on");
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b1, 1'b1, 1'b1, 1'b1), "all bits");
      @(posedge clk);
      #1;
      clr = 1'b1;
      @(posedge clk);
      #1;
      clr = 1'b0;
      readCheck(`RP_ADDR_MR, 16'h0000, "mr after clr");

      ////////////////////////////////////////////////////////////////////
      // Serial read decode
      ////////////////////////////////////////////////////////////////////

      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "mode on");
      for (i = 0; i < 16; i++)
         shiftBit(1'b0);
      readCheck(`RP_ADDR_MR, mrExpect(0, 1, 0, 0, 0, lastDrdd, 0, 0, 1, 1), "zero detect");

      // Sync byte, msb first
      for (i = 7; i >= 0; i--)
         shiftBit(syncByte[i]);
      readCheck(`RP_ADDR_MR, mrExpect(1, 0, 1, 0, 0, lastDrdd, 0, 0, 1, 1), "sync detect");

      // Alternating data, never sixteen zeros in a row
      for (i = 0; i < 16; i++)
         shiftBit(i[0]);
      readCheck(`RP_ADDR_MR, mrExpect(1, 0, 1, 0, 1, lastDrdd, 0, 0, 1, 1), "word clock");
      for (i = 16; i < 32; i++)
         shiftBit(i[0]);
      readCheck(`RP_ADDR_MR, mrExpect(1, 0, 0, 1, 0, lastDrdd, 0, 0, 1, 1), "ecc envelope");
      for (i = 0; i < 16; i++)
         shiftBit(i[0]);
      readCheck(`RP_ADDR_MR, mrExpect(0, 0, 0, 0, 0, lastDrdd, 0, 0, 1, 1), "ecc end");
      busWrite(`RP_ADDR_MR, mrWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), "mode off");

      ////////////////////////////////////////////////////////////////////
      // Sector counter
      ////////////////////////////////////////////////////////////////////

      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "mode on");
      // Past one wrap, but the count never lands back on zero
      n = $urandom_range(39, 21);
      for (i = 0; i < n; i++)
      begin
         busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b1, 1'b0), "sector clock high");
         busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "sector clock low");
      end
      readCheck(`RP_ADDR_LA, laExpect(n % SECTORS_PER_TRACK), "sector count");
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), "index high");
      busWrite(`RP_ADDR_MR, mrWord(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "index low");
      readCheck(`RP_ADDR_LA, laExpect(0), "sector after index");

      // Unknown addresses
      readCheck(5'd2, 16'h0000, "unknown address 2");
      readCheck(5'd5, 16'h0000, "unknown address 5");
      readCheck(5'd31, 16'h0000, "unknown address 31");
      busWrite(5'd2, '1, "write unknown address");
      readCheck(`RP_ADDR_MR, mrExpect(0, 0, 0, 0, 0, 0, 0, 0, 0, 1), "mr after unknown write");
      readCheck(`RP_ADDR_CS1, cs1Expect(5'd0, 1'b0), "cs1 after unknown write");

      repeat (4) @(posedge clk);
      assertFails = u_rpDrive.u_rpDriveAssert.failCount;
      $display("Done: %0d checks, %0d errors, %0d assertion failures",
               checks, errors, assertFails);
      if (errors == 0 && assertFails == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
